// ==== camCfgPkg.sv ====
package camCfgPkg;

   typedef logic [7:0]  slaveAddr_t;   // 7-bit address << 1, rd bit in lsb
   typedef logic [15:0] regAddr_t;     // sensor register pointer
   typedef logic [7:0]  regData_t;
   typedef logic [5:0]  tableIdx_t;    // script position

   // transfer kinds understood by the I2C engine
   typedef enum logic [1:0] {
      WRITE_REG = 2'd0,   // addr, ptr hi, ptr lo, data
      WRITE_PTR = 2'd1,   // addr, ptr hi, ptr lo
      READ_BYTE = 2'd2    // addr with rd bit, one byte in
   } cmdKind_t;

   typedef struct packed {
      cmdKind_t   kind;
      slaveAddr_t slave;
      regAddr_t   regAddr;
      regData_t   data;
   } i2cCmd_t;

   // one line of the register script
   typedef struct packed {
      slaveAddr_t slave;     // DELAY_MARK turns the line into a wait
      regAddr_t   regAddr;
      regData_t   data;      // wait length in cycles for delay lines
   } tableEntry_t;

   localparam slaveAddr_t SENSOR_ADDR = 8'h6C;
   localparam slaveAddr_t DELAY_MARK  = 8'hAA;
   localparam regAddr_t   ID_REG      = 16'h300B;
   localparam regData_t   SENSOR_ID   = 8'h88;

   localparam int SCRIPT_LEN   = 24;   // entries in the table
   localparam int UPDATE_START = 16;   // loop re-enters here
   localparam int ID_RETRY_GAP = 6;    // idle before another ID attempt
   localparam int CMD_GAP      = 3;    // idle between two commands

endpackage

// ==== cfgTable.sv ====
`timescale 1ns/1ps

module cfgTable import camCfgPkg::*; (
   input  logic        CLK_400K,
   input  tableIdx_t   tableIdx,
   input  regData_t    testReg,
   input  regAddr_t    wSize,
   input  regAddr_t    hSize,
   input  regAddr_t    expo,
   output tableEntry_t entry
);

   function automatic tableEntry_t wr(input regAddr_t r, input regData_t d);
      return '{slave: SENSOR_ADDR, regAddr: r, data: d};
   endfunction

   function automatic tableEntry_t dly(input regData_t cycles);
      return '{slave: DELAY_MARK, regAddr: 16'h0000, data: cycles};
   endfunction

   // registered read, entry follows the index by one clock
   always_ff @(posedge CLK_400K) begin
      case (tableIdx)
         6'd0:    entry <= wr(16'h0103, 8'h01);       // software reset
         6'd1:    entry <= dly(8'd10);
         6'd2:    entry <= wr(16'h0100, 8'h00);       // standby
         6'd3:    entry <= wr(16'h0302, 8'd24);       // pll1 multiplier
         6'd4:    entry <= wr(16'h0303, 8'h00);       // pll1 divm
         6'd5:    entry <= wr(16'h0304, 8'h03);       // pll1 mipi div
         6'd6:    entry <= wr(16'h030E, 8'h00);       // pll2 divs
         6'd7:    entry <= wr(16'h030F, 8'h04);
         6'd8:    entry <= wr(16'h3018, 8'h72);       // mipi 4 lane
         6'd9:    entry <= wr(16'h3020, 8'h93);       // clock normal
         6'd10:   entry <= wr(16'h3808, wSize[15:8]); // x size hi
         6'd11:   entry <= wr(16'h3809, wSize[7:0]);
         6'd12:   entry <= wr(16'h380A, hSize[15:8]); // y size hi
         6'd13:   entry <= wr(16'h380B, hSize[7:0]);
         6'd14:   entry <= wr(16'h5E00, testReg);     // test pattern
         6'd15:   entry <= wr(16'h0100, 8'h01);       // stream on
         // update block, rewritten every pass
         6'd16:   entry <= wr(16'h3501, expo[15:8]);  // exposure hi
         6'd17:   entry <= wr(16'h3502, expo[7:0]);
         6'd18:   entry <= wr(16'h5E00, testReg);
         6'd19:   entry <= wr(16'h3808, wSize[15:8]);
         6'd20:   entry <= wr(16'h3809, wSize[7:0]);
         6'd21:   entry <= wr(16'h380A, hSize[15:8]);
         6'd22:   entry <= wr(16'h380B, hSize[7:0]);
         6'd23:   entry <= dly(8'hFF);                // pause before next pass
         default: entry <= dly(8'h00);
      endcase
   end

endmodule

// ==== cfgSequencer.sv ====
`timescale 1ns/1ps

module cfgSequencer import camCfgPkg::*; (
   input  logic        CLK_400K,
   input  logic        RESET_N,
   input  tableEntry_t entry,
   output tableIdx_t   tableIdx,
   output i2cCmd_t     cmd,
   output logic        go,
   input  logic        done,
   input  regData_t    rdData,
   output regData_t    idByte,
   output logic        cameraRelease
);

   typedef enum logic [2:0] {
      ID_PTR,         // point at the ID register
      ID_READ,        // fetch the ID byte
      SCRIPT_ISSUE,   // act on the current table entry
      BUSY,           // transfer in flight
      GAP,            // idle between commands
      DELAY,          // scripted wait, bus quiet
      RETRY           // wrong ID, back off
   } seqState_t;

   seqState_t state;
   regData_t  cnt;       // gap, delay and retry counter
   tableIdx_t nextIdx;

   // last entry wraps into the update block
   assign nextIdx = (tableIdx == tableIdx_t'(SCRIPT_LEN - 1)) ? tableIdx_t'(UPDATE_START) :
                    tableIdx + tableIdx_t'(1);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state         <= ID_PTR;
         tableIdx      <= '0;
         cmd           <= '0;
         go            <= 1'b0;
         cnt           <= '0;
         idByte        <= '0;
         cameraRelease <= 1'b0;
      end else begin
         go <= 1'b0;   // single cycle pulse
         case (state)
            ID_PTR: begin
               cmd   <= '{kind: WRITE_PTR, slave: SENSOR_ADDR, regAddr: ID_REG, data: 8'h00};
               go    <= 1'b1;
               state <= BUSY;
            end
            ID_READ: begin
               cmd   <= '{kind: READ_BYTE, slave: SENSOR_ADDR, regAddr: ID_REG, data: 8'h00};
               go    <= 1'b1;
               state <= BUSY;
            end
            SCRIPT_ISSUE: begin
               if (entry.slave == DELAY_MARK) begin
                  cnt   <= '0;
                  state <= DELAY;
               end else begin
                  cmd.kind    <= WRITE_REG;
                  cmd.slave   <= entry.slave;
                  cmd.regAddr <= entry.regAddr;
                  cmd.data    <= entry.data;
                  go          <= 1'b1;
                  state       <= BUSY;
               end
            end
            BUSY: begin
               if (done) begin
                  cnt   <= '0;
                  state <= GAP;
                  case (cmd.kind)
                     READ_BYTE: begin
                        idByte <= rdData;
                        if (rdData != SENSOR_ID)
                           state <= RETRY;
                     end
                     WRITE_REG: begin
                        // stream-on entry sits just before the update block
                        if (tableIdx == tableIdx_t'(UPDATE_START - 1))
                           cameraRelease <= 1'b1;
                        tableIdx <= nextIdx;
                     end
                     default: ;   // pointer set, read comes next
                  endcase
               end
            end
            GAP: begin
               if (cnt == regData_t'(CMD_GAP - 1)) begin
                  if (cmd.kind == WRITE_PTR)
                     state <= ID_READ;
                  else
                     state <= SCRIPT_ISSUE;
               end else begin
                  cnt <= cnt + 8'd1;
               end
            end
            DELAY: begin
               if (cnt == entry.data) begin
                  tableIdx <= nextIdx;
                  cnt      <= '0;
                  state    <= GAP;   // also covers the table read latency
               end else begin
                  cnt <= cnt + 8'd1;
               end
            end
            RETRY: begin
               if (cnt == regData_t'(ID_RETRY_GAP - 1))
                  state <= ID_PTR;
               else
                  cnt <= cnt + 8'd1;
            end
            default: state <= ID_PTR;
         endcase
      end
   end

endmodule

// ==== i2cTransfer.sv ====
`timescale 1ns/1ps

module i2cTransfer import camCfgPkg::*; (
   input  logic     CLK_400K,
   input  logic     RESET_N,
   input  i2cCmd_t  cmd,
   input  logic     go,
   output logic     done,
   output regData_t rdData,
   input  logic     sdaIn,
   output logic     sdaOut,
   output logic     sdaOe,
   output logic     scl
);

   typedef enum logic [2:0] {
      IDLE,
      START_A,   // bus free, both lines high
      START_B,   // sda low under scl high
      BIT_LO,
      BIT_HI,
      STOP_LO,
      STOP_HI    // sda released on exit gives the stop
   } xferState_t;

   xferState_t state;
   logic [3:0] bitCnt;      // 0..7 data, 8 ack slot
   logic [1:0] byteCnt;
   logic [1:0] lastByte;
   logic [7:0] shiftReg;    // msb goes out first
   logic       readPhase;   // slave drives the data bits

   // byte sequence: address, pointer hi, pointer lo, data
   function automatic logic [7:0] byteAt(input logic [1:0] idx, input i2cCmd_t c);
      logic [7:0] b;
      case (idx)
         2'd0:    b = (c.kind == READ_BYTE) ? (c.slave | 8'h01) : c.slave;
         2'd1:    b = c.regAddr[15:8];
         2'd2:    b = c.regAddr[7:0];
         default: b = c.data;
      endcase
      return b;
   endfunction

   always_comb begin
      case (cmd.kind)
         WRITE_REG: lastByte = 2'd3;
         WRITE_PTR: lastByte = 2'd2;
         default:   lastByte = 2'd1;
      endcase
   end

   assign readPhase = (cmd.kind == READ_BYTE) && (byteCnt == 2'd1);
   assign done      = (state == STOP_HI);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state   <= IDLE;
         bitCnt  <= '0;
         byteCnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (go)
                  state <= START_A;
            end
            START_A: state <= START_B;
            START_B: begin
               bitCnt  <= '0;
               byteCnt <= '0;
               state   <= BIT_LO;
            end
            BIT_LO: state <= BIT_HI;
            BIT_HI: begin
               if (bitCnt != 4'd8) begin
                  bitCnt <= bitCnt + 4'd1;
                  state  <= BIT_LO;
               end else if (byteCnt == lastByte) begin
                  state <= STOP_LO;
               end else begin
                  bitCnt  <= '0;
                  byteCnt <= byteCnt + 2'd1;
                  state   <= BIT_LO;
               end
            end
            STOP_LO: state <= STOP_HI;
            default: state <= IDLE;
         endcase
      end
   end

   // shifts out on writes and samples sdaIn with scl high on reads
   always_ff @(posedge CLK_400K) begin
      if (state == START_B) begin
         shiftReg <= byteAt(2'd0, cmd);
      end else if (state == BIT_HI) begin
         if (bitCnt == 4'd8)
            shiftReg <= byteAt(byteCnt + 2'd1, cmd);
         else
            shiftReg <= {shiftReg[6:0], sdaIn};
      end
   end

   always_ff @(posedge CLK_400K) begin
      if (state == BIT_HI && readPhase && bitCnt == 4'd7)
         rdData <= {shiftReg[6:0], sdaIn};   // last data bit of the read
   end

   always_comb begin
      scl    = 1'b1;
      sdaOe  = 1'b0;
      sdaOut = 1'b1;
      case (state)
         START_B, STOP_HI: begin
            sdaOe  = 1'b1;
            sdaOut = 1'b0;
         end
         STOP_LO: begin
            scl    = 1'b0;
            sdaOe  = 1'b1;
            sdaOut = 1'b0;
         end
         BIT_LO, BIT_HI: begin
            scl = (state == BIT_HI);
            // ack slot and read bits leave the line to the slave, nack on read
            if (bitCnt != 4'd8 && !readPhase) begin
               sdaOe  = 1'b1;
               sdaOut = shiftReg[7];
            end
         end
         default: ;
      endcase
   end

endmodule

// ==== mipiCameraConfig.sv ====
`timescale 1ns/1ps

module mipiCameraConfig import camCfgPkg::*; (
   input  logic     CLK_400K,
   input  logic     RESET_N,
   input  regData_t testReg,
   input  regAddr_t wSize,
   input  regAddr_t hSize,
   input  regAddr_t expo,
   output logic     i2cScl,
   output logic     cameraRelease,
   output regData_t idByte,
   inout  wire      i2cSda
);

   tableIdx_t   tableIdx;
   tableEntry_t entry;
   i2cCmd_t     cmd;
   logic        go;
   logic        done;
   regData_t    rdData;
   logic        sdaOut;
   logic        sdaOe;

   cfgTable u_table (
      .CLK_400K (CLK_400K),
      .tableIdx (tableIdx),
      .testReg  (testReg),
      .wSize    (wSize),
      .hSize    (hSize),
      .expo     (expo),
      .entry    (entry)
   );

   cfgSequencer u_seq (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .entry         (entry),
      .tableIdx      (tableIdx),
      .cmd           (cmd),
      .go            (go),
      .done          (done),
      .rdData        (rdData),
      .idByte        (idByte),
      .cameraRelease (cameraRelease)
   );

   i2cTransfer u_xfer (
      .CLK_400K (CLK_400K),
      .RESET_N  (RESET_N),
      .cmd      (cmd),
      .go       (go),
      .done     (done),
      .rdData   (rdData),
      .sdaIn    (i2cSda),
      .sdaOut   (sdaOut),
      .sdaOe    (sdaOe),
      .scl      (i2cScl)
   );

   // open drain, only ever pulled low
   assign i2cSda = (sdaOe && !sdaOut) ? 1'b0 : 1'bz;

endmodule

// ==== sensorModel.sv ====
`timescale 1ns/1ps

module sensorModel import camCfgPkg::*; (
   input  logic        CLK_400K,
   input  logic        scl,
   inout  wire         sda,
   input  regData_t    idValue,
   output logic        wrStrobe,   // one cycle per finished register write
   output tableEntry_t wrEntry,
   output logic        inFrame     // between start and stop
);

   logic        sclPrev  = 1'b1;
   logic        sdaPrev  = 1'b1;
   logic        driveLow = 1'b0;
   logic [3:0]  bitIdx   = '0;     // bits seen in the current byte, 8 is the ack slot
   logic [2:0]  byteIdx  = '0;
   logic        isRead   = 1'b0;
   logic [7:0]  rxByte   = '0;
   logic [7:0]  txByte   = '0;
   tableEntry_t frame    = '0;

   assign sda = driveLow ? 1'b0 : 1'bz;

   initial begin
      wrStrobe = 1'b0;
      wrEntry  = '0;
      inFrame  = 1'b0;
   end

   // lines are sampled mid cycle, away from the master's edges
   always @(negedge CLK_400K) begin
      wrStrobe <= 1'b0;
      if (scl && sclPrev && sdaPrev && !sda) begin            // start
         inFrame <= 1'b1;
         bitIdx  = '0;
         byteIdx = '0;
         isRead  = 1'b0;
      end else if (scl && sclPrev && !sdaPrev && sda) begin   // stop
         if (inFrame && !isRead && byteIdx == 3'd4) begin
            wrEntry  <= frame;
            wrStrobe <= 1'b1;
         end
         inFrame <= 1'b0;
      end else if (inFrame && !sclPrev && scl) begin          // rising scl
         if (bitIdx < 4'd8)
            rxByte = {rxByte[6:0], sda};
         bitIdx = bitIdx + 4'd1;
      end else if (inFrame && sclPrev && !scl) begin          // falling scl
         if (bitIdx == 4'd9) begin
            byteIdx = byteIdx + 3'd1;
            bitIdx  = '0;
            txByte  = idValue;   // only used in the read byte
         end
         if (bitIdx == 4'd8) begin
            case (byteIdx)
               3'd0: begin
                  isRead      = rxByte[0];
                  frame.slave = {rxByte[7:1], 1'b0};
               end
               3'd1:    frame.regAddr[15:8] = rxByte;
               3'd2:    frame.regAddr[7:0]  = rxByte;
               default: frame.data          = rxByte;
            endcase
            driveLow <= !(isRead && byteIdx == 3'd1);   // master nacks the read byte
         end else begin
            driveLow <= isRead && byteIdx == 3'd1 && !txByte[3'd7 - bitIdx[2:0]];
         end
      end
      sclPrev = scl;
      sdaPrev = sda;
   end

endmodule

// ==== tbMipiCameraConfig.sv ====
`timescale 1ns/1ps

module tbMipiCameraConfig import camCfgPkg::*; ();

   localparam int MAX_CYCLES = 40000;

   logic        CLK_400K = 1'b0;
   logic        RESET_N;
   regData_t    testReg;
   regAddr_t    wSize;
   regAddr_t    hSize;
   regAddr_t    expo;
   regData_t    idValue;
   wire         i2cSda;
   logic        i2cScl;
   logic        cameraRelease;
   regData_t    idByte;
   logic        wrStrobe;
   logic        inFrame;
   tableEntry_t wrEntry;
   logic [31:0] rngState   = 32'd17;
   int          errors     = 0;
   int          cycles     = 0;
   int          wrCount    = 0;
   int          changeAt   = 1000;   // first write that may carry changed port values
   int          settleEnd  = 0;
   int          idleCnt    = 0;
   logic        streamSeen = 1'b0;
   logic        gapChecked = 1'b0;

   pullup (i2cSda);

   mipiCameraConfig u_dut (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .testReg       (testReg),
      .wSize         (wSize),
      .hSize         (hSize),
      .expo          (expo),
      .i2cScl        (i2cScl),
      .cameraRelease (cameraRelease),
      .idByte        (idByte),
      .i2cSda        (i2cSda)
   );

   sensorModel u_sensor (
      .CLK_400K (CLK_400K),
      .scl      (i2cScl),
      .sda      (i2cSda),
      .idValue  (idValue),
      .wrStrobe (wrStrobe),
      .wrEntry  (wrEntry),
      .inFrame  (inFrame)
   );

   initial begin
      forever #4 CLK_400K = ~CLK_400K;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic randomizePorts();
      rngState = xorshift(rngState);
      expo     = rngState[15:0];
      testReg  = rngState[23:16];
      rngState = xorshift(rngState);
      wSize    = rngState[15:0];
      hSize    = rngState[31:16];
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // script position of the n-th register write, delay lines carry none
   function automatic int scriptIndex(input int n);
      if (n == 0)
         return 0;
      if (n < 15)
         return n + 1;
      return UPDATE_START + (n - 15) % 7;
   endfunction

   function automatic tableEntry_t expectedEntry(input int idx);
      case (idx)
         0:       return '{SENSOR_ADDR, 16'h0103, 8'h01};
         2:       return '{SENSOR_ADDR, 16'h0100, 8'h00};
         10, 19:  return '{SENSOR_ADDR, 16'h3808, wSize[15:8]};
         11, 20:  return '{SENSOR_ADDR, 16'h3809, wSize[7:0]};
         12, 21:  return '{SENSOR_ADDR, 16'h380A, hSize[15:8]};
         13, 22:  return '{SENSOR_ADDR, 16'h380B, hSize[7:0]};
         14, 18:  return '{SENSOR_ADDR, 16'h5E00, testReg};
         15:      return '{SENSOR_ADDR, 16'h0100, 8'h01};
         16:      return '{SENSOR_ADDR, 16'h3501, expo[15:8]};
         17:      return '{SENSOR_ADDR, 16'h3502, expo[7:0]};
         default: return '{SENSOR_ADDR, 16'h0000, 8'h00};   // pll and mipi lines
      endcase
   endfunction

   // outputs settle after the rising edge, so checks run on the falling one
   always @(negedge CLK_400K) begin
      int          idx;
      tableEntry_t expEntry;
      if (cycles >= 1 && cycles <= 9) begin   // reset and first cycle after it
         checkValue("i2cScl", i2cScl, 1'b1);
         checkValue("i2cSda", i2cSda, 1'b1);
         checkValue("cameraRelease", cameraRelease, 1'b0);
         checkValue("idByte", idByte, 8'h00);
      end
      if (wrCount == 1 && !gapChecked) begin   // quiet bus across the delay line
         if (inFrame) begin
            assert (idleCnt >= 10) else begin
               errors++;
               $display("bus was idle for only %0d cycles across the delay entry", idleCnt);
            end
            gapChecked = 1'b1;
         end else if (i2cScl) begin
            idleCnt++;
         end
      end
      if (wrStrobe) begin
         idx      = scriptIndex(wrCount);
         expEntry = expectedEntry(idx);
         checkValue("idByte", idByte, SENSOR_ID);
         checkValue("wrEntry.slave", wrEntry.slave, SENSOR_ADDR);
         if (idx < 3 || idx > 9) begin
            checkValue("wrEntry.regAddr", wrEntry.regAddr, expEntry.regAddr);
            if (wrCount < changeAt || wrCount >= settleEnd)
               checkValue("wrEntry.data", wrEntry.data, expEntry.data);
         end
         if (idx == 15)
            streamSeen = 1'b1;
         checkValue("cameraRelease", cameraRelease, streamSeen);
         wrCount++;
      end else if (streamSeen) begin
         checkValue("cameraRelease", cameraRelease, 1'b1);
      end else if (wrCount == 0 || !i2cScl) begin
         checkValue("cameraRelease", cameraRelease, 1'b0);   // ID stage or mid transfer
      end
   end

   initial begin
      RESET_N = 1'b0;
      idValue = 8'h55;   // wrong ID first
      randomizePorts();
      repeat (8) @(posedge CLK_400K);
      #1 RESET_N = 1'b1;
      while (idByte == 8'h00)
         @(posedge CLK_400K);
      checkValue("idByte", idByte, 8'h55);
      repeat (300) @(posedge CLK_400K);
      #1 idValue = SENSOR_ID;
      while (wrCount < 18)   // midway through the first update pass
         @(posedge CLK_400K);
      #1 randomizePorts();
      changeAt  = wrCount;
      settleEnd = wrCount + (7 - (wrCount - 15) % 7) % 7;
      while (wrCount < settleEnd + 14)   // two full passes with the new values
         @(posedge CLK_400K);
      assert (gapChecked) else begin
         errors++;
         $display("no idle gap was measured across the delay entry");
      end
      $display("run finished after %0d cycles with %0d errors", cycles, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge CLK_400K);
         cycles++;
      end
      $display("timeout after %0d cycles, the configuration never finished", cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
camCfgPkg.sv
cfgTable.sv
cfgSequencer.sv
i2cTransfer.sv
mipiCameraConfig.sv
sensorModel.sv
tbMipiCameraConfig.sv
